// File: filelist.f
+incdir+.
vrf_pkg.sv
vrf_lane_if.sv
vrf_addr_counter.sv
vrf_lane.sv
vrf_dispatch.sv
vrf_collect.sv
vrf_top.sv
tb_vrf.sv

// File: run.sh
#!/bin/sh
# Builds the vector register file testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_vrf -f filelist.f -o Vtb_vrf

out=$(./obj_dir/Vtb_vrf 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi

// File: tb_vrf_tests.svh
`ifndef TB_VRF_TESTS_SVH
`define TB_VRF_TESTS_SVH

// Reset values, bus latencies and a first CMD.
task automatic reset_state();
    logic [31:0] data;
    for (int l = 0; l < NL; l++) begin
        wb_read(6'(`REG_RBUF0 + l), data);
        check_value(data, 32'd0, "RBUF after reset");
    end
    wb_read(`REG_MASK, data);
    check_value(data, 32'((1 << NL) - 1), "MASK after reset");
    wb_read(`REG_MODE, data);
    check_value(data, 32'd0, "MODE after reset");
    wb_read(6'h3f, data);
    check_value(data, 32'd0, "unmapped address");
    run_cmd(vrf_pkg::OP_RESTART);
endtask

task automatic word_up_order();
    set_mode(1'b1, vrf_pkg::SEW_WORD);
    set_slide(9'd0);
    set_bases(9'h000, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(5);
    run_cmd(vrf_pkg::OP_RESTART);
    read_steps(5);
    // A full group shifts the bases, so reload before reading.
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(LOC);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(LOC);
endtask

task automatic base_cross_slide();
    set_mode(1'b1, vrf_pkg::SEW_WORD);
    set_slide(9'd3);
    set_bases(9'h040, 9'h020);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(LOC + 4);
    // Same words reached through bases 0x43 and 0x60 with no slide.
    set_slide(9'd0);
    set_bases(9'h043, 9'h01d);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(LOC + 4);
endtask

task automatic narrow_widths();
    set_mode(1'b1, vrf_pkg::SEW_BYTE);
    set_slide(9'd0);
    set_bases(9'h100, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(8);                             // Two words, four steps each.
    set_mode(1'b1, vrf_pkg::SEW_HALF);
    set_bases(9'h140, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(6);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(6);
    // Word reads show the last narrow write per word.
    set_mode(1'b1, vrf_pkg::SEW_WORD);
    set_bases(9'h100, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(2);
    set_bases(9'h140, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(3);
endtask

task automatic down_count();
    set_mode(1'b0, vrf_pkg::SEW_WORD);
    set_slide(9'd2);
    set_bases(9'h180, 9'h020);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(LOC + 2);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(LOC + 2);
    // Ascending view of the first group, starting at 0x17e.
    set_mode(1'b1, vrf_pkg::SEW_WORD);
    set_slide(9'd0);
    set_bases(9'h17e, 9'h022);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(LOC);
endtask

task automatic lane_mask();
    set_mode(1'b1, vrf_pkg::SEW_WORD);
    set_slide(9'd0);
    set_bases(9'h1c0, 9'h010);
    run_cmd(vrf_pkg::OP_LOAD);
    write_steps(LOC);
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(1);
    set_mask(4'b1011);                          // Lane 2 off.
    write_steps(2);
    read_steps(2);
    // Lane 2 resumes where it stopped.
    set_mask(4'b1111);
    read_steps(2);
    // Words written while lane 2 was off.
    run_cmd(vrf_pkg::OP_LOAD);
    read_steps(3);
endtask

`endif

// File: tb_vrf.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module tb_vrf;

    localparam int NL         = `VLANE_NUM;
    localparam int LOC        = `VREG_LOC_PER_LANE;
    localparam int MAX_CYCLES = 20000;      // Whole run needs under 2000.

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [31:0]          wb_dat_w;
    logic [31:0]          wb_dat_r;
    logic                 wb_ack;
    logic [31:0]          rng;
    int                   cycle_cnt = 0;

    // Reference model, one bank copy and counter state per lane.
    logic [31:0]   ref_mem  [NL][`MEM_DEPTH];
    logic [8:0]    ref_base [NL][`BASE_NUM];
    int            ref_cnt  [NL];
    logic [31:0]   ref_rbuf [NL];
    logic [8:0]    cfg_base [`BASE_NUM];
    logic [8:0]    cfg_slide;
    logic          cfg_up;
    vrf_pkg::sew_e cfg_sew;
    logic [NL-1:0] cfg_mask;
    logic [31:0]   cfg_wbuf [NL];

    vrf_top DUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Word offset shift per element width. Limit is (LOC << shift) - 1.
    function automatic int elem_shift(input vrf_pkg::sew_e sew);
        case (sew)
            vrf_pkg::SEW_BYTE: return 2;
            vrf_pkg::SEW_HALF: return 1;
            default:           return 0;
        endcase
    endfunction

    task automatic wb_transfer(input logic we, input logic [`WB_ADR_W-1:0] adr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
        check_value(32'(wb_ack), 32'd0, "ack high with no transfer");
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        cycles   = 0;
        do begin
            @(posedge clk_i);
            #2;
            cycles++;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk_i);                       // Slave back in idle.
        #2;
    endtask

    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] data,
                            input int exp_cycles);
        logic [31:0] unused;
        int          cycles;
        wb_transfer(1'b1, adr, data, unused, cycles);
        check_value(32'(cycles), 32'(exp_cycles), $sformatf("write ack delay at %h", adr));
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] data);
        int cycles;
        wb_transfer(1'b0, adr, 32'd0, data, cycles);
        check_value(32'(cycles), 32'd1, $sformatf("read ack delay at %h", adr));
    endtask

    task automatic model_step(input logic write);
        int         lim;
        logic [8:0] a;
        lim = (LOC << elem_shift(cfg_sew)) - 1;
        for (int l = 0; l < NL; l++) begin
            if (cfg_mask[l]) begin
                a = 9'(int'(ref_base[l][0]) + (ref_cnt[l] >> elem_shift(cfg_sew)));
                if (write) begin
                    ref_mem[l][a] = cfg_wbuf[l];
                end else begin
                    ref_rbuf[l] = ref_mem[l][a];
                end
                if (ref_cnt[l] == (cfg_up ? lim : 0)) begin
                    ref_cnt[l] = cfg_up ? 0 : lim;  // Next register group.
                    for (int k = 0; k < `BASE_NUM - 1; k++) begin
                        ref_base[l][k] = ref_base[l][k+1];
                    end
                    ref_base[l][`BASE_NUM-1] = '0;
                end else begin
                    ref_cnt[l] = cfg_up ? ref_cnt[l] + 1 : ref_cnt[l] - 1;
                end
            end
        end
    endtask

    task automatic run_cmd(input vrf_pkg::opcode_e op);
        int lim;
        lim = (LOC << elem_shift(cfg_sew)) - 1;
        wb_write(`REG_CMD, 32'(op), 3);
        for (int l = 0; l < NL; l++) begin
            if (op == vrf_pkg::OP_LOAD) begin
                for (int k = 0; k < `BASE_NUM; k++) begin
                    ref_base[l][k] = cfg_base[k];
                end
                ref_base[l][0] = cfg_up ? cfg_base[0] + cfg_slide : cfg_base[0] - cfg_slide;
            end
            if (op == vrf_pkg::OP_LOAD || op == vrf_pkg::OP_RESTART) begin
                ref_cnt[l] = cfg_up ? 0 : lim;
            end
        end
        if (op == vrf_pkg::OP_WRITE || op == vrf_pkg::OP_READ) begin
            model_step(op == vrf_pkg::OP_WRITE);
        end
    endtask

    task automatic set_mode(input logic up, input vrf_pkg::sew_e sew);
        cfg_up  = up;
        cfg_sew = sew;
        wb_write(`REG_MODE, {29'd0, sew, up}, 1);
    endtask

    task automatic set_slide(input logic [8:0] slide);
        cfg_slide = slide;
        wb_write(`REG_SLIDE, 32'(slide), 1);
    endtask

    task automatic set_mask(input logic [NL-1:0] mask);
        cfg_mask = mask;
        wb_write(`REG_MASK, 32'(mask), 1);
    endtask

    task automatic set_bases(input logic [8:0] first, input logic [8:0] gap);
        for (int k = 0; k < `BASE_NUM; k++) begin
            cfg_base[k] = first + 9'(k) * gap;
            wb_write(6'(`REG_BASE0 + k), 32'(cfg_base[k]), 1);
        end
    endtask

    task automatic write_steps(input int n);
        repeat (n) begin
            for (int l = 0; l < NL; l++) begin
                rng = xorshift(rng);
                cfg_wbuf[l] = rng;
                wb_write(6'(`REG_WBUF0 + l), rng, 1);
            end
            run_cmd(vrf_pkg::OP_WRITE);
        end
    endtask

    task automatic read_steps(input int n);
        logic [31:0] data;
        repeat (n) begin
            run_cmd(vrf_pkg::OP_READ);
            for (int l = 0; l < NL; l++) begin
                wb_read(6'(`REG_RBUF0 + l), data);
                check_value(data, ref_rbuf[l], $sformatf("RBUF of lane %0d", l));
            end
        end
    endtask

    `include "tb_vrf_tests.svh"

    initial begin
        rst_i    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rng      = 32'hc5b78a07;
        cfg_slide = '0;
        cfg_up    = 1'b0;
        cfg_sew   = vrf_pkg::SEW_BYTE;
        cfg_mask  = '1;
        for (int l = 0; l < NL; l++) begin
            ref_cnt[l]  = 0;
            ref_rbuf[l] = '0;
            cfg_wbuf[l] = '0;
            for (int k = 0; k < `BASE_NUM; k++) begin
                ref_base[l][k] = '0;
            end
        end
        for (int k = 0; k < `BASE_NUM; k++) begin
            cfg_base[k] = '0;
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b1;

        reset_state();
        word_up_order();
        base_cross_slide();
        narrow_widths();
        down_count();
        lane_mask();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vrf_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module vrf_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADR_W-1:0]  wb_adr_i,
    input  logic [`DATA_W-1:0]    wb_dat_i,
    output logic [`DATA_W-1:0]    wb_dat_o,
    output logic                  wb_ack_o
);

    logic                               capture;
    logic [`VLANE_NUM-1:0][`DATA_W-1:0] rbuf;

    vrf_lane_if lane_if [`VLANE_NUM] ();

    vrf_dispatch u_dispatch (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .rbuf_i    (rbuf),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .capture_o (capture),
        .lanes     (lane_if)
    );

    for (genvar g = 0; g < `VLANE_NUM; g++) begin : g_lane
        vrf_lane u_lane (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .lane  (lane_if[g])
        );
    end

    vrf_collect u_collect (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .capture_i (capture),
        .lanes     (lane_if),
        .rbuf_o    (rbuf)
    );

endmodule

`default_nettype wire

// File: vrf_collect.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module vrf_collect (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                capture_i,
    vrf_lane_if.coll                            lanes [`VLANE_NUM],
    output logic [`VLANE_NUM-1:0][`DATA_W-1:0]  rbuf_o
);

    for (genvar g = 0; g < `VLANE_NUM; g++) begin : g_rbuf
        logic [`DATA_W-1:0] rbuf_q;

        // A masked lane keeps its last value.
        always_ff @(posedge clk_i) begin
            if (!rst_i) begin
                rbuf_q <= '0;
            end else if (capture_i && lanes[g].lane_en) begin
                rbuf_q <= lanes[g].rdata;
            end
        end

        assign rbuf_o[g] = rbuf_q;
    end

endmodule

`default_nettype wire

// File: vrf_dispatch.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module vrf_dispatch (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [`WB_ADR_W-1:0]                wb_adr_i,
    input  logic [`DATA_W-1:0]                  wb_dat_i,
    input  logic [`VLANE_NUM-1:0][`DATA_W-1:0]  rbuf_i,
    output logic [`DATA_W-1:0]                  wb_dat_o,
    output logic                                wb_ack_o,
    output logic                                capture_o,
    vrf_lane_if.disp                            lanes [`VLANE_NUM]
);

    localparam int AW  = `ADDR_W;
    localparam int BIW = $clog2(`BASE_NUM);
    localparam int LIW = $clog2(`VLANE_NUM);

    vrf_pkg::disp_state_e               state_q;
    logic [`BASE_NUM-1:0][AW-1:0]       base_q;
    logic [AW-1:0]                      slide_q;
    logic                               up_q;
    vrf_pkg::sew_e                      sew_q;
    logic [`VLANE_NUM-1:0]              mask_q;
    logic [`VLANE_NUM-1:0][`DATA_W-1:0] wbuf_q;
    logic                               load_q;
    logic                               restart_q;
    logic                               step_q;
    logic                               we_q;
    logic                               req;
    logic [`WB_ADR_W-1:0]               base_off;
    logic [`WB_ADR_W-1:0]               wbuf_off;
    logic [`WB_ADR_W-1:0]               rbuf_off;
    logic                               is_base;
    logic                               is_wbuf;
    logic                               is_rbuf;
    logic [`DATA_W-1:0]                 rd_data;

    assign req = wb_cyc_i && wb_stb_i;

    // Offsets wrap below each window, so one compare per window.
    assign base_off = wb_adr_i - `REG_BASE0;
    assign wbuf_off = wb_adr_i - `REG_WBUF0;
    assign rbuf_off = wb_adr_i - `REG_RBUF0;
    assign is_base  = base_off < `BASE_NUM;
    assign is_wbuf  = wbuf_off < `VLANE_NUM;
    assign is_rbuf  = rbuf_off < `VLANE_NUM;

    always_comb begin
        rd_data = '0;
        if (is_base) begin
            rd_data[AW-1:0] = base_q[base_off[BIW-1:0]];
        end else if (wb_adr_i == `REG_SLIDE) begin
            rd_data[AW-1:0] = slide_q;
        end else if (wb_adr_i == `REG_MODE) begin
            rd_data[2:0] = {sew_q, up_q};
        end else if (wb_adr_i == `REG_MASK) begin
            rd_data[`VLANE_NUM-1:0] = mask_q;
        end else if (is_wbuf) begin
            rd_data = wbuf_q[wbuf_off[LIW-1:0]];
        end else if (is_rbuf) begin
            rd_data = rbuf_i[rbuf_off[LIW-1:0]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == vrf_pkg::ST_IDLE && req) begin
            wb_dat_o <= rd_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= vrf_pkg::ST_IDLE;
            wb_ack_o  <= 1'b0;
            capture_o <= 1'b0;
            load_q    <= 1'b0;
            restart_q <= 1'b0;
            step_q    <= 1'b0;
            we_q      <= 1'b0;
            base_q    <= '0;
            slide_q   <= '0;
            up_q      <= 1'b0;
            sew_q     <= vrf_pkg::SEW_BYTE;
            mask_q    <= '1;                    // All lanes on.
            wbuf_q    <= '0;
        end else begin
            load_q    <= 1'b0;
            restart_q <= 1'b0;
            step_q    <= 1'b0;
            capture_o <= 1'b0;
            wb_ack_o  <= 1'b0;
            case (state_q)
                vrf_pkg::ST_IDLE: begin
                    if (req && wb_we_i && wb_adr_i == `REG_CMD) begin
                        state_q <= vrf_pkg::ST_STEP;
                        case (vrf_pkg::opcode_e'(wb_dat_i[1:0]))
                            vrf_pkg::OP_LOAD:    load_q    <= 1'b1;
                            vrf_pkg::OP_RESTART: restart_q <= 1'b1;
                            vrf_pkg::OP_WRITE: begin
                                step_q <= 1'b1;
                                we_q   <= 1'b1;
                            end
                            vrf_pkg::OP_READ: begin
                                step_q <= 1'b1;
                                we_q   <= 1'b0;
                            end
                        endcase
                    end else if (req) begin
                        state_q  <= vrf_pkg::ST_ACK;
                        wb_ack_o <= 1'b1;
                        if (wb_we_i) begin
                            if (is_base) begin
                                base_q[base_off[BIW-1:0]] <= wb_dat_i[AW-1:0];
                            end else if (wb_adr_i == `REG_SLIDE) begin
                                slide_q <= wb_dat_i[AW-1:0];
                            end else if (wb_adr_i == `REG_MODE) begin
                                up_q  <= wb_dat_i[0];
                                sew_q <= vrf_pkg::sew_e'(wb_dat_i[2:1]);
                            end else if (wb_adr_i == `REG_MASK) begin
                                mask_q <= wb_dat_i[`VLANE_NUM-1:0];
                            end else if (is_wbuf) begin
                                wbuf_q[wbuf_off[LIW-1:0]] <= wb_dat_i;
                            end
                        end
                    end
                end
                vrf_pkg::ST_STEP: begin
                    capture_o <= step_q && !we_q;   // Read data lands next edge.
                    state_q   <= vrf_pkg::ST_LATCH;
                end
                vrf_pkg::ST_LATCH: begin
                    wb_ack_o <= 1'b1;
                    state_q  <= vrf_pkg::ST_ACK;
                end
                default: state_q <= vrf_pkg::ST_IDLE;   // Ack seen by master.
            endcase
        end
    end

    for (genvar g = 0; g < `VLANE_NUM; g++) begin : g_bcast
        assign lanes[g].load         = load_q;
        assign lanes[g].restart      = restart_q;
        assign lanes[g].step         = step_q;
        assign lanes[g].we           = we_q;
        assign lanes[g].up_down      = up_q;
        assign lanes[g].sew          = sew_q;
        assign lanes[g].start_addr   = base_q;
        assign lanes[g].slide_offset = slide_q;
        assign lanes[g].lane_en      = mask_q[g];
        assign lanes[g].wdata        = wbuf_q[g];
    end

endmodule

`default_nettype wire

// File: vrf_lane.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module vrf_lane #(
    parameter STRIDE_ENABLE = "YES"
) (
    input  logic        clk_i,
    input  logic        rst_i,
    vrf_lane_if.lane    lane
);

    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] mem [`MEM_DEPTH];
    logic [`DATA_W-1:0] rdata_q;

    vrf_addr_counter #(
        .STRIDE_ENABLE   (STRIDE_ENABLE)
    ) u_addr_counter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_addr_i    (lane.start_addr),
        .slide_offset_i  (lane.slide_offset),
        .load_i          (lane.load),
        .rst_cnt_i       (lane.restart),
        .up_down_i       (lane.up_down),
        .element_width_i (lane.sew),
        .en_i            (lane.step),
        .lane_en_i       (lane.lane_en),
        .addr_o          (addr)
    );

    // Bank access uses the address from before the counter moves.
    always_ff @(posedge clk_i) begin
        if (lane.step) begin
            if (lane.we && lane.lane_en) begin
                mem[addr] <= lane.wdata;
            end
            rdata_q <= mem[addr];               // Old data on a write step.
        end
    end

    assign lane.rdata = rdata_q;

endmodule

`default_nettype wire

// File: vrf_addr_counter.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

module vrf_addr_counter #(
    parameter STRIDE_ENABLE = "YES"
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [`BASE_NUM*`ADDR_W-1:0]  start_addr_i,
    input  logic [`ADDR_W-1:0]            slide_offset_i,
    input  logic                          load_i,
    input  logic                          rst_cnt_i,
    input  logic                          up_down_i,       // 1 counts up.
    input  vrf_pkg::sew_e                 element_width_i,
    input  logic                          en_i,
    input  logic                          lane_en_i,
    output logic [`ADDR_W-1:0]            addr_o
);

    localparam int AW  = `ADDR_W;
    localparam int CW  = `CNT_W;
    localparam int LOC = `VREG_LOC_PER_LANE;

    logic [`BASE_NUM-1:0][AW-1:0] base_q;
    logic [CW-1:0]                cnt_q;
    logic [CW-1:0]                cnt_limit;
    logic [CW-1:0]                cnt_word;     // Element count as word offset.
    logic [CW-1:0]                cnt_start;
    logic                         cnt_end;
    logic                         dir_up;
    logic                         advance;
    logic [AW-1:0]                base0_load;

    if (STRIDE_ENABLE == "YES") begin : g_stride
        assign dir_up = up_down_i;
    end else begin : g_up_only
        assign dir_up = 1'b1;                   // Direction input ignored.
    end

    // Several narrow elements share one word.
    always_comb begin
        case (element_width_i)
            vrf_pkg::SEW_BYTE: begin
                cnt_limit = CW'(4 * LOC - 1);
                cnt_word  = {2'b00, cnt_q[CW-1:2]};
            end
            vrf_pkg::SEW_HALF: begin
                cnt_limit = CW'(2 * LOC - 1);
                cnt_word  = {1'b0, cnt_q[CW-1:1]};
            end
            vrf_pkg::SEW_WORD: begin
                cnt_limit = CW'(LOC - 1);
                cnt_word  = cnt_q;
            end
            default: begin
                cnt_limit = '0;
                cnt_word  = '0;
            end
        endcase
    end

    assign cnt_start = dir_up ? '0 : cnt_limit;
    assign cnt_end   = dir_up ? (cnt_q == cnt_limit) : (cnt_q == '0);
    assign advance   = en_i && lane_en_i && !load_i && !rst_cnt_i;

    // Slide applies to the first base only.
    assign base0_load = dir_up ? start_addr_i[AW-1:0] + slide_offset_i
                               : start_addr_i[AW-1:0] - slide_offset_i;

    assign addr_o = base_q[0] + AW'(cnt_word);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            base_q <= '0;
        end else if (load_i) begin
            base_q[0] <= base0_load;
            for (int i = 1; i < `BASE_NUM; i++) begin
                base_q[i] <= start_addr_i[i*AW +: AW];
            end
        end else if (advance && cnt_end) begin
            for (int i = 1; i < `BASE_NUM; i++) begin
                base_q[i-1] <= base_q[i];
            end
            base_q[`BASE_NUM-1] <= '0;          // Zeros fill from the top.
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else if (load_i || rst_cnt_i) begin
            cnt_q <= cnt_start;
        end else if (advance) begin
            if (cnt_end) begin
                cnt_q <= cnt_start;
            end else if (dir_up) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: vrf_lane_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "vrf_defs.svh"

interface vrf_lane_if;

    // Broadcast control, same for every lane.
    logic                          load;
    logic                          restart;
    logic                          step;
    logic                          we;
    logic                          up_down;
    vrf_pkg::sew_e                 sew;
    logic [`BASE_NUM*`ADDR_W-1:0]  start_addr;
    logic [`ADDR_W-1:0]            slide_offset;

    // Per-lane signals.
    logic                          lane_en;
    logic [`DATA_W-1:0]            wdata;
    logic [`DATA_W-1:0]            rdata;

    modport disp (
        output load, restart, step, we, up_down, sew, start_addr, slide_offset,
        output lane_en, wdata
    );

    modport lane (
        input  load, restart, step, we, up_down, sew, start_addr, slide_offset,
        input  lane_en, wdata,
        output rdata
    );

    modport coll (
        input lane_en, rdata
    );

endinterface

`default_nettype wire

// File: vrf_pkg.sv
`default_nettype none

package vrf_pkg;

    // Element width of a step.
    typedef enum logic [1:0] {
        SEW_BYTE = 2'b00,
        SEW_HALF = 2'b01,
        SEW_WORD = 2'b10
    } sew_e;

    // Low bits of a CMD write.
    typedef enum logic [1:0] {
        OP_LOAD    = 2'b00,
        OP_RESTART = 2'b01,
        OP_WRITE   = 2'b10,
        OP_READ    = 2'b11
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STEP,
        ST_LATCH,
        ST_ACK
    } disp_state_e;

endpackage

`default_nettype wire

// File: vrf_defs.svh
`ifndef VRF_DEFS_SVH
`define VRF_DEFS_SVH

// Lane and bank geometry.
`define VLANE_NUM           4
`define MEM_DEPTH           512
`define ADDR_W              9
`define VREG_LOC_PER_LANE   8
`define CNT_W               5
`define DATA_W              32
`define BASE_NUM            8      // Register bases walked per load.

// Wishbone register map, word addresses.
`define WB_ADR_W            6
`define REG_BASE0           6'h00
`define REG_SLIDE           6'h08
`define REG_MODE            6'h09
`define REG_MASK            6'h0A
`define REG_CMD             6'h0B
`define REG_WBUF0           6'h10
`define REG_RBUF0           6'h20

`endif
